// ==== dv/tb_mpu.sv ====
// MPU testbench
// Loads random programs, launches threads and checks the instruction
// stream and status levels against a reference model

`timescale 1ns/1ns
`default_nettype none

`include "mpu_consts.svh"

module tb_mpu;
	import pkg_mpu::*;

	localparam int MAX_CYCLES	= 4000;		// Six tests of under 300 cycles each
	localparam int DEPTH		= `MPU_SIZE_THREAD_MEM;
	localparam int NUM_ISSUE	= `MPU_NUM_ISSUE;

	logic		clock;
	logic		rst_n;
	logic		wr_req;
	host_wr_t	wr_data;
	logic		run_req;
	id_t		run_id;
	logic		commit_req;
	issue_no_t	commit_no;
	logic		issue_req;
	issue_t		issue_data;
	mpu_stat_t	status;

	integer		seed;
	int			cycle;
	int			errors;
	int			tests_run;
	int			tests_failed;

	////////////////////
	// Reference model

	instr_t		mem_m [DEPTH];
	int			used_m;
	logic		valid_m [`MPU_NUM_THREAD];
	int			base_m [`MPU_NUM_THREAD];
	int			len_m [`MPU_NUM_THREAD];
	int			next_no_m;
	logic		pend_m [NUM_ISSUE];		// Outstanding issue numbers
	logic		mem_full_m;
	logic		bad_m;
	int			loaded_q [$];			// IDs with a valid entry

	issue_t		stream_q [$];			// Words seen on the stream
	int			stream_cyc [$];

	mpu DUT (
		.clock		(clock),
		.rst_n		(rst_n),
		.wr_req		(wr_req),
		.wr_data	(wr_data),
		.run_req	(run_req),
		.run_id		(run_id),
		.commit_req	(commit_req),
		.commit_no	(commit_no),
		.issue_req	(issue_req),
		.issue_data	(issue_data),
		.status		(status)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	initial begin
		wait (cycle >= MAX_CYCLES);
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	// Stream monitor on the falling edge
	always @(negedge clock) begin
		if (rst_n && issue_req) begin
			stream_q.push_back(issue_data);
			stream_cyc.push_back(cycle);
		end
	end

	////////////////////
	// Helpers

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic int last_issued();
		return (next_no_m + NUM_ISSUE - 1) % NUM_ISSUE;
	endfunction

	task automatic check_status(input string name);
		check({name, " window_full"}, 32'(pend_m[next_no_m]), 32'(status.window_full));
		check({name, " mem_full"}, 32'(mem_full_m), 32'(status.mem_full));
		check({name, " bad_thread"}, 32'(bad_m), 32'(status.bad_thread));
		check({name, " busy"}, 32'(0), 32'(status.busy));
	endtask

	task automatic load_program(input int id, input int len, input string name);
		int		base;
		logic	rej;
		instr_t	ins;
		base = used_m;
		rej = 1'b0;
		for (int i = 0; i < len; i++) begin
			ins = instr_t'($random(seed));
			@(posedge clock);
			wr_req			<= 1'b1;
			wr_data.id		<= id_t'(id);
			wr_data.instr	<= ins;
			wr_data.last	<= (i == len - 1);
			if (rej || used_m == DEPTH) begin	// No room so the whole load is dropped
				rej = 1'b1;
				mem_full_m = 1'b1;
			end else begin
				mem_m[used_m] = ins;
				used_m++;
			end
		end
		@(posedge clock);
		wr_req <= 1'b0;
		if (!rej) begin
			if (!valid_m[id])
				loaded_q.push_back(id);
			valid_m[id] = 1'b1;
			base_m[id] = base;
			len_m[id] = len;
		end
		repeat (2) @(posedge clock);			// Map entry settles
		@(negedge clock);
		check_status(name);
	endtask

	task automatic run_thread(input int id, input string name);
		int exp_len;
		int exp_no;
		int run_cyc;
		stream_q.delete();
		stream_cyc.delete();
		exp_len = 0;
		exp_no = next_no_m;
		if (!valid_m[id]) begin
			bad_m = 1'b1;
		end else if (!pend_m[next_no_m]) begin
			exp_len = len_m[id];
			pend_m[next_no_m] = 1'b1;
			next_no_m = (next_no_m + 1) % NUM_ISSUE;
		end
		@(posedge clock);
		run_req	<= 1'b1;
		run_id	<= id_t'(id);
		@(posedge clock);
		run_req <= 1'b0;
		@(negedge clock);
		run_cyc = cycle;						// Cycle of the run sample
		check({name, " busy after run"}, 32'(1), 32'(status.busy));
		while (status.busy)
			@(negedge clock);
		@(negedge clock);
		check({name, " length"}, 32'(exp_len), 32'(stream_q.size()));
		for (int i = 0; i < exp_len && i < stream_q.size(); i++) begin
			check({name, " instr"}, 32'(mem_m[base_m[id] + i]), 32'(stream_q[i].instr));
			check({name, " issue_no"}, 32'(exp_no), 32'(stream_q[i].issue_no));
			check({name, " last"}, 32'(i == exp_len - 1), 32'(stream_q[i].last));
			check({name, " timing"}, 32'(run_cyc + 3 + i), 32'(stream_cyc[i]));
		end
		check_status(name);
	endtask

	task automatic commit_issue(input int n);
		@(posedge clock);
		commit_req	<= 1'b1;
		commit_no	<= issue_no_t'(n);
		@(posedge clock);
		commit_req <= 1'b0;
		pend_m[n] = 1'b0;
	endtask

	task automatic commit_all();
		for (int n = 0; n < NUM_ISSUE; n++) begin
			if (pend_m[n])
				commit_issue(n);
		end
	endtask

	////////////////////
	// Test sequence

	initial begin
		int err_start;
		int id;
		int prev_no;
		int freed;
		seed = 32'hb76ac5ca;
		rst_n		<= 1'b0;
		wr_req		<= 1'b0;
		wr_data		<= '0;
		run_req		<= 1'b0;
		run_id		<= '0;
		commit_req	<= 1'b0;
		commit_no	<= '0;
		used_m = 0;
		next_no_m = 0;
		mem_full_m = 1'b0;
		bad_m = 1'b0;
		for (int i = 0; i < `MPU_NUM_THREAD; i++)
			valid_m[i] = 1'b0;
		for (int i = 0; i < NUM_ISSUE; i++)
			pend_m[i] = 1'b0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_status("reset");

		// Random programs that are each run and committed
		err_start = errors;
		for (int t = 0; t < 4; t++)
			load_program(rand_below(6), 1 + rand_below(4), "load_run");
		foreach (loaded_q[k]) begin
			run_thread(loaded_q[k], "load_run");
			commit_issue(last_issued());
		end
		end_test("load_run", err_start);

		// Issue numbers count up and wrap
		err_start = errors;
		prev_no = last_issued();
		for (int t = 0; t < 6; t++) begin
			run_thread(loaded_q[rand_below(loaded_q.size())], "issue_wrap");
			if (stream_q.size() > 0)
				check("issue_wrap step", 32'((prev_no + 1) % NUM_ISSUE),
					32'(stream_q[0].issue_no));
			prev_no = last_issued();
			commit_issue(prev_no);
		end
		end_test("issue_wrap", err_start);

		// Fill the window and free the oldest number
		err_start = errors;
		for (int t = 0; t < NUM_ISSUE; t++)
			run_thread(loaded_q[rand_below(loaded_q.size())], "window_full");
		check("window_full level", 32'(1), 32'(status.window_full));
		run_thread(loaded_q[0], "window_full drop");
		freed = next_no_m;
		commit_issue(freed);
		run_thread(loaded_q[0], "window_full rerun");
		if (stream_q.size() > 0)
			check("window_full freed no", 32'(freed), 32'(stream_q[0].issue_no));
		commit_all();
		end_test("window_full", err_start);

		// Thread ID 7 is never loaded
		err_start = errors;
		run_thread(7, "bad_thread");
		check("bad_thread level", 32'(1), 32'(status.bad_thread));
		end_test("bad_thread", err_start);

		// New program into a used ID
		err_start = errors;
		id = loaded_q[rand_below(loaded_q.size())];
		load_program(id, 1 + rand_below(4), "reload");
		run_thread(id, "reload");
		commit_all();
		end_test("reload", err_start);

		// Overflow the thread memory
		err_start = errors;
		id = rand_below(7);
		load_program(id, DEPTH - used_m + 3, "mem_full");
		check("mem_full level", 32'(1), 32'(status.mem_full));
		run_thread(id, "mem_full");
		commit_all();
		end_test("mem_full", err_start);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mpu.f ====
+incdir+src
src/pkg_mpu.sv
src/thread_mem.sv
src/map_man.sv
src/commit_window.sv
src/dispatch.sv
src/mpu.sv
dv/tb_mpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MPU testbench with Verilator and run it
verilator --binary --timing -Wno-fatal -f mpu.f --top-module tb_mpu -o tb_mpu &&
	./obj_dir/tb_mpu | tee /dev/stderr | grep -q "Simulation PASSED" &&
	echo "run_sim: simulation reported success" ||
	{ echo "run_sim: build or simulation did not succeed"; exit 1; }

// ==== src/commit_window.sv ====
// Commit window
// Hands out issue numbers in order and holds each one until the
// processing units commit it

`timescale 1ns/1ns
`default_nettype none

`include "mpu_consts.svh"

module commit_window (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						alloc_req,
	output	pkg_mpu::issue_no_t			alloc_no,
	output	logic						window_full,
	input	wire						commit_req,
	input	pkg_mpu::issue_no_t			commit_no
);
	import pkg_mpu::*;

	issue_no_t					next_no;
	logic [`MPU_NUM_ISSUE-1:0]	outstanding;
	logic [`MPU_NUM_ISSUE-1:0]	outstanding_nxt;

	assign alloc_no		= next_no;
	assign window_full	= outstanding[next_no];	// Next number still in flight

	always_comb begin
		outstanding_nxt = outstanding;
		// Clearing an idle bit leaves it idle
		if (commit_req)
			outstanding_nxt[commit_no] = 1'b0;
		if (alloc_req)
			outstanding_nxt[next_no] = 1'b1;	// Wins over a commit of the same idle number
	end

	////////////////////
	// Window state

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			next_no		<= '0;
			outstanding	<= '0;
		end else begin
			outstanding <= outstanding_nxt;
			if (alloc_req) begin
				if (next_no == issue_no_t'(`MPU_NUM_ISSUE - 1))
					next_no <= '0;
				else
					next_no <= next_no + issue_no_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/dispatch.sv ====
// Dispatcher
// Looks up a launched thread, takes an issue number and streams the
// thread's instructions out one per cycle, tagged with that number

`timescale 1ns/1ns
`default_nettype none

module dispatch (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						run_req,
	input	pkg_mpu::id_t				run_id,
	output	pkg_mpu::id_t				lookup_id,
	input	pkg_mpu::thread_info_t		lookup_info,
	output	logic						alloc_req,
	input	pkg_mpu::issue_no_t			alloc_no,
	input	wire						window_full,
	output	logic						rd_req,
	output	pkg_mpu::t_address_t		rd_addr,
	input	pkg_mpu::instr_t			rd_instr,
	output	logic						issue_req,
	output	pkg_mpu::issue_t			issue_data,
	output	logic						busy,
	output	logic						bad_thread
);
	import pkg_mpu::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CHECK,
		ST_STREAM,
		ST_DRAIN
	} state_t;

	state_t			state;
	thread_info_t	info_q;			// Registered map entry
	issue_no_t		issue_no_q;
	t_address_t		addr_q;
	t_address_t		cnt_q;			// Words left to read
	logic			rd_valid_q;
	logic			last_q;
	logic			rd_last;

	assign lookup_id	= run_id;
	assign alloc_req	= (state == ST_CHECK) && info_q.valid && !window_full;
	assign rd_req		= (state == ST_STREAM);
	assign rd_addr		= addr_q;
	assign rd_last		= (cnt_q == t_address_t'(1));
	assign busy			= (state != ST_IDLE);

	////////////////////
	// Launch FSM

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state		<= ST_IDLE;
			bad_thread	<= 1'b0;
			rd_valid_q	<= 1'b0;
			issue_req	<= 1'b0;
		end else begin
			rd_valid_q	<= rd_req;
			issue_req	<= rd_valid_q;		// Word leaves one cycle after read data
			case (state)
				ST_IDLE: begin
					if (run_req)
						state <= ST_CHECK;
				end
				ST_CHECK: begin
					if (!info_q.valid) begin
						bad_thread	<= 1'b1;	// Sticky
						state		<= ST_IDLE;
					end else if (window_full) begin
						state <= ST_IDLE;		// Run dropped
					end else begin
						state <= ST_STREAM;
					end
				end
				ST_STREAM: begin
					if (rd_last)
						state <= ST_DRAIN;
				end
				ST_DRAIN: begin
					state <= ST_IDLE;			// Last word is in the output stage
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Stream datapath

	always_ff @(posedge clock) begin
		if ((state == ST_IDLE) && run_req)
			info_q <= lookup_info;
		if (alloc_req) begin
			issue_no_q	<= alloc_no;
			addr_q		<= info_q.base;
			cnt_q		<= info_q.length;
		end
		if (rd_req) begin
			addr_q	<= addr_q + t_address_t'(1);
			cnt_q	<= cnt_q - t_address_t'(1);
		end
		last_q					<= rd_req && rd_last;	// Aligned with read data
		issue_data.instr		<= rd_instr;
		issue_data.issue_no		<= issue_no_q;
		issue_data.last			<= last_q;
	end

endmodule

`default_nettype wire

// ==== src/map_man.sv ====
// Map manager
// Per-thread table of base address and length, written on each completed
// load and read combinationally by the dispatcher

`timescale 1ns/1ns
`default_nettype none

`include "mpu_consts.svh"

module map_man (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						store_req,
	input	pkg_mpu::id_t				store_id,
	input	pkg_mpu::thread_info_t		store_info,
	input	pkg_mpu::id_t				lookup_id,
	output	pkg_mpu::thread_info_t		lookup_info
);
	import pkg_mpu::*;

	thread_info_t	table_q [`MPU_NUM_THREAD];

	assign lookup_info = table_q[lookup_id];	// Combinational lookup

	////////////////////
	// Entry table

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `MPU_NUM_THREAD; i++) begin
				table_q[i] <= '0;					// All entries invalid
			end
		end else if (store_req) begin
			// A reload of the same ID simply overwrites it
			table_q[store_id] <= store_info;
		end
	end

endmodule

`default_nettype wire

// ==== src/mpu.sv ====
// MPU top level
// Connects thread memory, map manager, commit window and dispatcher,
// and gathers the host status levels

`timescale 1ns/1ns
`default_nettype none

module mpu (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						wr_req,
	input	pkg_mpu::host_wr_t			wr_data,
	input	wire						run_req,
	input	pkg_mpu::id_t				run_id,
	input	wire						commit_req,
	input	pkg_mpu::issue_no_t			commit_no,
	output	logic						issue_req,
	output	pkg_mpu::issue_t			issue_data,
	output	pkg_mpu::mpu_stat_t			status
);
	import pkg_mpu::*;

	logic			store_req;
	id_t			store_id;
	thread_info_t	store_info;
	id_t			lookup_id;
	thread_info_t	lookup_info;
	logic			alloc_req;
	issue_no_t		alloc_no;
	logic			window_full;
	logic			rd_req;
	t_address_t		rd_addr;
	instr_t			rd_instr;
	logic			mem_full;
	logic			busy;
	logic			bad_thread;

	assign status.busy			= busy;
	assign status.mem_full		= mem_full;
	assign status.window_full	= window_full;
	assign status.bad_thread	= bad_thread;

	////////////////////
	// Blocks

	thread_mem thread_mem (
		.clock		(clock),
		.rst_n		(rst_n),
		.wr_req		(wr_req),
		.wr_data	(wr_data),
		.rd_req		(rd_req),
		.rd_addr	(rd_addr),
		.rd_instr	(rd_instr),
		.store_req	(store_req),
		.store_id	(store_id),
		.store_info	(store_info),
		.mem_full	(mem_full)
	);

	map_man map_man (
		.clock			(clock),
		.rst_n			(rst_n),
		.store_req		(store_req),
		.store_id		(store_id),
		.store_info		(store_info),
		.lookup_id		(lookup_id),
		.lookup_info	(lookup_info)
	);

	commit_window commit_window (
		.clock			(clock),
		.rst_n			(rst_n),
		.alloc_req		(alloc_req),
		.alloc_no		(alloc_no),
		.window_full	(window_full),
		.commit_req		(commit_req),
		.commit_no		(commit_no)
	);

	dispatch dispatch (
		.clock			(clock),
		.rst_n			(rst_n),
		.run_req		(run_req),
		.run_id			(run_id),
		.lookup_id		(lookup_id),
		.lookup_info	(lookup_info),
		.alloc_req		(alloc_req),
		.alloc_no		(alloc_no),
		.window_full	(window_full),
		.rd_req			(rd_req),
		.rd_addr		(rd_addr),
		.rd_instr		(rd_instr),
		.issue_req		(issue_req),
		.issue_data		(issue_data),
		.busy			(busy),
		.bad_thread		(bad_thread)
	);

endmodule

`default_nettype wire

// ==== src/mpu_consts.svh ====
// MPU numeric limits
// Sizes of the thread memory, thread table and issue window, and the instruction width

`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

`define MPU_SIZE_THREAD_MEM	32	// Thread memory depth in words
`define MPU_NUM_THREAD		8	// Number of thread IDs
`define MPU_NUM_ISSUE		4	// Outstanding issue window
`define MPU_INSTR_W			16	// Instruction width

`endif

// ==== src/pkg_mpu.sv ====
// MPU shared types
// Index types and packed structs used across the master processing unit

`default_nettype none

`include "mpu_consts.svh"

package pkg_mpu;

	typedef logic [`MPU_INSTR_W-1:0]						instr_t;
	typedef logic [$clog2(`MPU_NUM_THREAD)-1:0]			id_t;
	typedef logic [$clog2(`MPU_SIZE_THREAD_MEM):0]		t_address_t;	// One extra bit for full count
	typedef logic [$clog2(`MPU_NUM_ISSUE)-1:0]			issue_no_t;

	////////////////////
	// Packed structs

	typedef struct packed {
		id_t		id;
		instr_t		instr;
		logic		last;		// Final word of a program
	} host_wr_t;

	typedef struct packed {
		logic		valid;
		t_address_t	base;
		t_address_t	length;
	} thread_info_t;

	typedef struct packed {
		instr_t		instr;
		issue_no_t	issue_no;
		logic		last;		// Final word of the stream
	} issue_t;

	typedef struct packed {
		logic		busy;
		logic		mem_full;
		logic		window_full;
		logic		bad_thread;
	} mpu_stat_t;

endpackage

`default_nettype wire

// ==== src/thread_mem.sv ====
// Thread memory
// Stores host-loaded programs with a bump allocator and announces each
// complete load to the map manager. Registered read port for dispatch.

`timescale 1ns/1ns
`default_nettype none

`include "mpu_consts.svh"

module thread_mem (
	input	wire						clock,
	input	wire						rst_n,
	input	wire						wr_req,
	input	pkg_mpu::host_wr_t			wr_data,
	input	wire						rd_req,
	input	pkg_mpu::t_address_t		rd_addr,
	output	pkg_mpu::instr_t			rd_instr,
	output	logic						store_req,
	output	pkg_mpu::id_t				store_id,
	output	pkg_mpu::thread_info_t		store_info,
	output	logic						mem_full
);
	import pkg_mpu::*;

	localparam int AW = $clog2(`MPU_SIZE_THREAD_MEM);

	instr_t			mem [`MPU_SIZE_THREAD_MEM];
	t_address_t		wr_ptr;			// Used size
	t_address_t		load_base;		// Base of load in progress
	logic			load_rej;		// Load in progress was rejected
	logic			in_load;
	t_address_t		cur_base;
	logic			cur_rej;
	logic			full_now;
	logic			wr_ok;

	// First word of a load starts at the current pointer
	assign cur_base	= in_load ? load_base : wr_ptr;
	assign cur_rej	= in_load ? load_rej : 1'b0;
	assign full_now	= (wr_ptr == t_address_t'(`MPU_SIZE_THREAD_MEM));
	assign wr_ok	= wr_req && !cur_rej && !full_now;

	////////////////////
	// Load tracking

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr		<= '0;
			load_base	<= '0;
			load_rej	<= 1'b0;
			in_load		<= 1'b0;
			store_req	<= 1'b0;
			mem_full	<= 1'b0;
		end else begin
			store_req <= wr_req && wr_data.last && !cur_rej && !full_now;
			if (wr_ok)
				wr_ptr <= wr_ptr + t_address_t'(1);
			if (wr_req && full_now)
				mem_full <= 1'b1;					// Sticky
			if (wr_req) begin
				in_load		<= !wr_data.last;
				load_base	<= cur_base;
				load_rej	<= !wr_data.last && (cur_rej || full_now);
			end
		end
	end

	////////////////////
	// Storage and entry

	always_ff @(posedge clock) begin
		if (wr_ok)
			mem[wr_ptr[AW-1:0]] <= wr_data.instr;
		if (rd_req)
			rd_instr <= mem[rd_addr[AW-1:0]];
		if (wr_req && wr_data.last) begin
			store_id			<= wr_data.id;
			store_info.valid	<= 1'b1;
			store_info.base		<= cur_base;
			store_info.length	<= wr_ptr + t_address_t'(1) - cur_base;	// Includes last word
		end
	end

endmodule

`default_nettype wire
